// File: rtl/board_map_pkg.sv
`default_nettype none

package board_map_pkg;

  // **************************************************
  // Processor bus geometry
  // **************************************************

  localparam int UP_ADDR_W = 4;
  localparam int UP_DATA_W = 32;

  // **************************************************
  // Register addresses
  // **************************************************

  // Board outputs, read/write
  localparam logic [UP_ADDR_W-1:0] ADDR_BD_OUT = 4'd0;
  // Synchronized board inputs, read-only
  localparam logic [UP_ADDR_W-1:0] ADDR_BD_IN = 4'd1;
  // Channel control words, one per transceiver
  localparam logic [UP_ADDR_W-1:0] ADDR_CHAN0_CTRL = 4'd2;
  localparam logic [UP_ADDR_W-1:0] ADDR_CHAN1_CTRL = 4'd3;
  // Status of both channels, a read clears the change flags
  localparam logic [UP_ADDR_W-1:0] ADDR_CHAN_STATUS = 4'd4;
  // Sync request, synthesizer enable and lock
  localparam logic [UP_ADDR_W-1:0] ADDR_MISC = 4'd5;

  // **************************************************
  // Field positions
  // **************************************************

  // Status register layout
  localparam int STAT0_LSB = 0;
  localparam int STAT1_LSB = 8;
  localparam int CHG0_BIT  = 16;
  localparam int CHG1_BIT  = 17;

  // Misc register layout, lock is read-only
  localparam int MISC_SYNC_BIT = 0;
  localparam int MISC_RFEN_BIT = 1;
  localparam int MISC_LOCK_BIT = 2;

endpackage

`default_nettype wire

// File: rtl/xcvr_ctrl_pkg.sv
`default_nettype none

package xcvr_ctrl_pkg;

  // Width of one channel control word
  localparam int CHAN_CTRL_W = 9;

  // Width of the transceiver status bus
  localparam int STATUS_W = 8;

  // **************************************************
  // Channel control word
  // **************************************************

  // The register bank sees a raw word for write and read-back,
  // while the channel controller looks at the same bits as pins
  typedef union packed {
    logic [CHAN_CTRL_W-1:0] raw;
    struct packed {
      // Transceiver control inputs
      logic [3:0] ctl;
      // Transceiver reset, active low
      logic       resetb;
      logic       en_agc;
      // High selects enable and txnrx from the word, low from the core
      logic       pin_mode;
      logic       enable;
      logic       txnrx;
    } pin;
  } chan_ctrl_u;

  // Power-up value of the word
  // Resetb is low so the transceiver stays in reset until software
  // releases it, and the core owns enable and txnrx
  localparam logic [CHAN_CTRL_W-1:0] CHAN_CTRL_RST = {
    4'h0,
    1'b0,
    1'b0,
    1'b0,
    1'b0,
    1'b0
  };

endpackage

`default_nettype wire

// File: rtl/xcvr_chan_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module xcvr_chan_ctrl #(
  parameter int SYNC_STAGES = 3
) (
  input  wire                                ref_clk,
  input  wire                                sys_100m_resetn,

  // Control word from the register bank
  input  wire xcvr_ctrl_pkg::chan_ctrl_u     ctrl_i,

  // Enable and txnrx requested by the datapath core
  input  wire                                core_enable_i,
  input  wire                                core_txnrx_i,

  // Asynchronous status bus from the transceiver
  input  wire  [xcvr_ctrl_pkg::STATUS_W-1:0] status_i,
  input  wire                                status_clr_i,

  // Transceiver control pins
  output logic                               resetb_o,
  output logic                               en_agc_o,
  output logic [3:0]                         ctl_o,
  output logic                               enable_o,
  output logic                               txnrx_o,

  // Synchronized status and its sticky change flag
  output logic [xcvr_ctrl_pkg::STATUS_W-1:0] status_o,
  output logic                               status_chg_o
);

  logic [SYNC_STAGES-1:0][xcvr_ctrl_pkg::STATUS_W-1:0] status_sync;
  logic [xcvr_ctrl_pkg::STATUS_W-1:0]                  status_prev;
  logic                                                enable_s;
  logic                                                txnrx_s;

  // **************************************************
  // Control pins
  // **************************************************

  // Pin mode hands enable and txnrx to software, otherwise the
  // datapath core toggles them directly
  always_comb begin
    if (ctrl_i.pin.pin_mode) begin
      enable_s = ctrl_i.pin.enable;
      txnrx_s  = ctrl_i.pin.txnrx;
    end else begin
      enable_s = core_enable_i;
      txnrx_s  = core_txnrx_i;
    end
  end

  always_ff @(posedge ref_clk or negedge sys_100m_resetn) begin
    if (!sys_100m_resetn) begin
      resetb_o <= 1'b0;
      en_agc_o <= 1'b0;
      ctl_o    <= 4'h0;
      enable_o <= 1'b0;
      txnrx_o  <= 1'b0;
    end else begin
      resetb_o <= ctrl_i.pin.resetb;
      en_agc_o <= ctrl_i.pin.en_agc;
      ctl_o    <= ctrl_i.pin.ctl;
      enable_o <= enable_s;
      txnrx_o  <= txnrx_s;
    end
  end

  // **************************************************
  // Status synchronizer and change detect
  // **************************************************

  // The status bus is quasi-static, so each bit goes through its own
  // chain of flops
  always_ff @(posedge ref_clk or negedge sys_100m_resetn) begin
    if (!sys_100m_resetn) begin
      status_sync <= '0;
      status_prev <= '0;
    end else begin
      status_sync[0] <= status_i;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        status_sync[i] <= status_sync[i-1];
      end
      status_prev <= status_o;
    end
  end

  assign status_o = status_sync[SYNC_STAGES-1];

  // A new change wins over a clear in the same cycle so that no
  // transition goes unseen by software
  always_ff @(posedge ref_clk or negedge sys_100m_resetn) begin
    if (!sys_100m_resetn) begin
      status_chg_o <= 1'b0;
    end else if (status_o != status_prev) begin
      status_chg_o <= 1'b1;
    end else if (status_clr_i) begin
      status_chg_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/gpio_regs.sv
`timescale 1ns/1ns
`default_nettype none

module gpio_regs #(
  parameter int SYNC_STAGES = 3,
  parameter int BD_IN_W     = 13,
  parameter int BD_OUT_W    = 8
) (
  input  wire                                   ref_clk,
  input  wire                                   sys_100m_resetn,

  // Processor strobes
  input  wire                                   up_wr_i,
  input  wire                                   up_rd_i,
  input  wire  [board_map_pkg::UP_ADDR_W-1:0]   up_addr_i,
  input  wire  [board_map_pkg::UP_DATA_W-1:0]   up_wdata_i,
  output logic [board_map_pkg::UP_DATA_W-1:0]   up_rdata_o,
  output logic                                  up_rack_o,

  // Board GPIO
  input  wire  [BD_IN_W-1:0]                    gpio_bd_i,
  output logic [BD_OUT_W-1:0]                   gpio_bd_o,

  // Synthesizer
  input  wire                                   pll_lock_i,
  output logic                                  rf_en_o,

  // Multi-chip sync pulse
  output logic                                  mcs_sync_o,

  // Channel controls
  output xcvr_ctrl_pkg::chan_ctrl_u             chan0_ctrl_o,
  output xcvr_ctrl_pkg::chan_ctrl_u             chan1_ctrl_o,

  // Channel status
  input  wire  [xcvr_ctrl_pkg::STATUS_W-1:0]    chan0_status_i,
  input  wire  [xcvr_ctrl_pkg::STATUS_W-1:0]    chan1_status_i,
  input  wire                                   chan0_chg_i,
  input  wire                                   chan1_chg_i,
  output logic                                  status_clr_o
);

  logic                                   mcs_req;
  logic [SYNC_STAGES-1:0][BD_IN_W-1:0]    bd_in_sync;
  logic [SYNC_STAGES-1:0]                 lock_sync;
  logic [SYNC_STAGES-1:0]                 mcs_sync_m;
  logic                                   mcs_last_q;
  logic [board_map_pkg::UP_DATA_W-1:0]    rdata_s;

  // **************************************************
  // Write decode
  // **************************************************

  always_ff @(posedge ref_clk or negedge sys_100m_resetn) begin
    if (!sys_100m_resetn) begin
      gpio_bd_o        <= '0;
      chan0_ctrl_o.raw <= xcvr_ctrl_pkg::CHAN_CTRL_RST;
      chan1_ctrl_o.raw <= xcvr_ctrl_pkg::CHAN_CTRL_RST;
      mcs_req          <= 1'b0;
      rf_en_o          <= 1'b0;
    end else if (up_wr_i) begin
      case (up_addr_i)
        board_map_pkg::ADDR_BD_OUT: begin
          gpio_bd_o <= up_wdata_i[BD_OUT_W-1:0];
        end
        board_map_pkg::ADDR_CHAN0_CTRL: begin
          chan0_ctrl_o.raw <= up_wdata_i[xcvr_ctrl_pkg::CHAN_CTRL_W-1:0];
        end
        board_map_pkg::ADDR_CHAN1_CTRL: begin
          chan1_ctrl_o.raw <= up_wdata_i[xcvr_ctrl_pkg::CHAN_CTRL_W-1:0];
        end
        board_map_pkg::ADDR_MISC: begin
          mcs_req <= up_wdata_i[board_map_pkg::MISC_SYNC_BIT];
          rf_en_o <= up_wdata_i[board_map_pkg::MISC_RFEN_BIT];
        end
        default: begin
        end
      endcase
    end
  end

  // **************************************************
  // Read-back
  // **************************************************

  always_comb begin
    rdata_s = '0;
    case (up_addr_i)
      board_map_pkg::ADDR_BD_OUT: rdata_s[BD_OUT_W-1:0] = gpio_bd_o;
      board_map_pkg::ADDR_BD_IN: rdata_s[BD_IN_W-1:0] = bd_in_sync[SYNC_STAGES-1];
      board_map_pkg::ADDR_CHAN0_CTRL: begin
        rdata_s[xcvr_ctrl_pkg::CHAN_CTRL_W-1:0] = chan0_ctrl_o.raw;
      end
      board_map_pkg::ADDR_CHAN1_CTRL: begin
        rdata_s[xcvr_ctrl_pkg::CHAN_CTRL_W-1:0] = chan1_ctrl_o.raw;
      end
      board_map_pkg::ADDR_CHAN_STATUS: begin
        rdata_s[board_map_pkg::STAT0_LSB +: xcvr_ctrl_pkg::STATUS_W] = chan0_status_i;
        rdata_s[board_map_pkg::STAT1_LSB +: xcvr_ctrl_pkg::STATUS_W] = chan1_status_i;
        rdata_s[board_map_pkg::CHG0_BIT] = chan0_chg_i;
        rdata_s[board_map_pkg::CHG1_BIT] = chan1_chg_i;
      end
      board_map_pkg::ADDR_MISC: begin
        rdata_s[board_map_pkg::MISC_SYNC_BIT] = mcs_req;
        rdata_s[board_map_pkg::MISC_RFEN_BIT] = rf_en_o;
        rdata_s[board_map_pkg::MISC_LOCK_BIT] = lock_sync[SYNC_STAGES-1];
      end
      default: rdata_s = '0;
    endcase
  end

  // Data is only driven while the acknowledge is high
  always_ff @(posedge ref_clk or negedge sys_100m_resetn) begin
    if (!sys_100m_resetn) begin
      up_rack_o    <= 1'b0;
      up_rdata_o   <= '0;
      status_clr_o <= 1'b0;
    end else begin
      up_rack_o    <= up_rd_i;
      up_rdata_o   <= up_rd_i ? rdata_s : '0;
      status_clr_o <= up_rd_i && (up_addr_i == board_map_pkg::ADDR_CHAN_STATUS);
    end
  end

  // **************************************************
  // Input synchronizers and multi-chip sync
  // **************************************************

  always_ff @(posedge ref_clk or negedge sys_100m_resetn) begin
    if (!sys_100m_resetn) begin
      bd_in_sync <= '0;
      lock_sync  <= '0;
      mcs_sync_m <= '0;
    end else begin
      bd_in_sync[0] <= gpio_bd_i;
      lock_sync[0]  <= pll_lock_i;
      mcs_sync_m[0] <= mcs_req;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        bd_in_sync[i] <= bd_in_sync[i-1];
        lock_sync[i]  <= lock_sync[i-1];
        mcs_sync_m[i] <= mcs_sync_m[i-1];
      end
    end
  end

  // One pulse on the falling edge of the request
  always_ff @(posedge ref_clk or negedge sys_100m_resetn) begin
    if (!sys_100m_resetn) begin
      mcs_last_q <= 1'b0;
      mcs_sync_o <= 1'b0;
    end else begin
      mcs_last_q <= mcs_sync_m[SYNC_STAGES-1];
      mcs_sync_o <= mcs_last_q & ~mcs_sync_m[SYNC_STAGES-1];
    end
  end

endmodule

`default_nettype wire

// File: rtl/xcvr_board_top.sv
`timescale 1ns/1ns
`default_nettype none

module xcvr_board_top #(
  parameter int SYNC_STAGES = 3,
  parameter int BD_IN_W     = 13,
  parameter int BD_OUT_W    = 8
) (
  input  wire                                 ref_clk,
  input  wire                                 sys_100m_resetn,

  // Processor side
  input  wire                                 up_wr_i,
  input  wire                                 up_rd_i,
  input  wire  [board_map_pkg::UP_ADDR_W-1:0] up_addr_i,
  input  wire  [board_map_pkg::UP_DATA_W-1:0] up_wdata_i,
  output logic [board_map_pkg::UP_DATA_W-1:0] up_rdata_o,
  output logic                                up_rack_o,

  // Board
  input  wire  [BD_IN_W-1:0]                  gpio_bd_i,
  output logic [BD_OUT_W-1:0]                 gpio_bd_o,
  input  wire                                 pll_lock_i,
  output logic                                rf_en_o,
  output logic                                mcs_sync_o,

  // Channel 0
  input  wire  [xcvr_ctrl_pkg::STATUS_W-1:0]  status_0_i,
  input  wire                                 core_enable_0_i,
  input  wire                                 core_txnrx_0_i,
  output logic                                resetb_0_o,
  output logic                                en_agc_0_o,
  output logic [3:0]                          ctl_0_o,
  output logic                                enable_0_o,
  output logic                                txnrx_0_o,

  // Channel 1
  input  wire  [xcvr_ctrl_pkg::STATUS_W-1:0]  status_1_i,
  input  wire                                 core_enable_1_i,
  input  wire                                 core_txnrx_1_i,
  output logic                                resetb_1_o,
  output logic                                en_agc_1_o,
  output logic [3:0]                          ctl_1_o,
  output logic                                enable_1_o,
  output logic                                txnrx_1_o
);

  xcvr_ctrl_pkg::chan_ctrl_u          chan0_ctrl;
  xcvr_ctrl_pkg::chan_ctrl_u          chan1_ctrl;
  logic [xcvr_ctrl_pkg::STATUS_W-1:0] chan0_status;
  logic [xcvr_ctrl_pkg::STATUS_W-1:0] chan1_status;
  logic                               chan0_chg;
  logic                               chan1_chg;
  logic                               status_clr;

  // Register bank shared by both channels
  gpio_regs #(
    .SYNC_STAGES (SYNC_STAGES),
    .BD_IN_W     (BD_IN_W),
    .BD_OUT_W    (BD_OUT_W)
  ) u_regs (
    .ref_clk         (ref_clk),
    .sys_100m_resetn (sys_100m_resetn),
    .up_wr_i         (up_wr_i),
    .up_rd_i         (up_rd_i),
    .up_addr_i       (up_addr_i),
    .up_wdata_i      (up_wdata_i),
    .up_rdata_o      (up_rdata_o),
    .up_rack_o       (up_rack_o),
    .gpio_bd_i       (gpio_bd_i),
    .gpio_bd_o       (gpio_bd_o),
    .pll_lock_i      (pll_lock_i),
    .rf_en_o         (rf_en_o),
    .mcs_sync_o      (mcs_sync_o),
    .chan0_ctrl_o    (chan0_ctrl),
    .chan1_ctrl_o    (chan1_ctrl),
    .chan0_status_i  (chan0_status),
    .chan1_status_i  (chan1_status),
    .chan0_chg_i     (chan0_chg),
    .chan1_chg_i     (chan1_chg),
    .status_clr_o    (status_clr)
  );

  xcvr_chan_ctrl #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_chan0 (
    .ref_clk         (ref_clk),
    .sys_100m_resetn (sys_100m_resetn),
    .ctrl_i          (chan0_ctrl),
    .core_enable_i   (core_enable_0_i),
    .core_txnrx_i    (core_txnrx_0_i),
    .status_i        (status_0_i),
    .status_clr_i    (status_clr),
    .resetb_o        (resetb_0_o),
    .en_agc_o        (en_agc_0_o),
    .ctl_o           (ctl_0_o),
    .enable_o        (enable_0_o),
    .txnrx_o         (txnrx_0_o),
    .status_o        (chan0_status),
    .status_chg_o    (chan0_chg)
  );

  xcvr_chan_ctrl #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_chan1 (
    .ref_clk         (ref_clk),
    .sys_100m_resetn (sys_100m_resetn),
    .ctrl_i          (chan1_ctrl),
    .core_enable_i   (core_enable_1_i),
    .core_txnrx_i    (core_txnrx_1_i),
    .status_i        (status_1_i),
    .status_clr_i    (status_clr),
    .resetb_o        (resetb_1_o),
    .en_agc_o        (en_agc_1_o),
    .ctl_o           (ctl_1_o),
    .enable_o        (enable_1_o),
    .txnrx_o         (txnrx_1_o),
    .status_o        (chan1_status),
    .status_chg_o    (chan1_chg)
  );

endmodule

`default_nettype wire

// File: dv/xcvr_board_tb_table.svh
`ifndef XCVR_BOARD_TB_TABLE_SVH
`define XCVR_BOARD_TB_TABLE_SVH

// Operations that a table entry can request
typedef enum logic [2:0] {
  OP_WRITE,
  OP_READ,
  OP_WAIT,
  OP_PINS,
  OP_STATUS,
  OP_CORE
} op_e;

// OP_WAIT takes the cycle count from data, and exp is the number of mcs_sync_o pulses
// OP_PINS compares exp with {mcs_sync, rf_en, gpio_bd[7:0], chan1 pins, chan0 pins}
// Each channel shows as {ctl[3:0], resetb, en_agc, enable, txnrx}
// With rnd set, a read adds the model of the driven inputs to exp, and a pin check
// takes enable and txnrx from the last core drive
typedef struct packed {
  logic [2:0]  tst;
  op_e         op;
  logic [3:0]  addr;
  logic [31:0] data;
  logic [31:0] exp;
  logic        rnd;
} entry_t;

localparam int NUM_ENTRIES = 39;

localparam entry_t STIM_TABLE [NUM_ENTRIES] = '{
  '{3'd1, OP_PINS, 4'd0, 32'h0, 32'h0, 1'b0},
  '{3'd1, OP_READ, board_map_pkg::ADDR_CHAN0_CTRL, 32'h0, 32'h0, 1'b0},
  '{3'd1, OP_READ, board_map_pkg::ADDR_CHAN1_CTRL, 32'h0, 32'h0, 1'b0},
  '{3'd1, OP_READ, board_map_pkg::ADDR_MISC, 32'h0, 32'h0, 1'b0},
  '{3'd2, OP_WRITE, board_map_pkg::ADDR_BD_OUT, 32'hFFFF_FFA5, 32'h0, 1'b0},
  '{3'd2, OP_READ, board_map_pkg::ADDR_BD_OUT, 32'h0, 32'h0000_00A5, 1'b0},
  '{3'd2, OP_WRITE, board_map_pkg::ADDR_CHAN0_CTRL, 32'h0000_F15E, 32'h0, 1'b0},
  '{3'd2, OP_WRITE, board_map_pkg::ADDR_CHAN1_CTRL, 32'h0000_00B5, 32'h0, 1'b0},
  '{3'd2, OP_WRITE, board_map_pkg::ADDR_MISC, 32'h0000_0002, 32'h0, 1'b0},
  '{3'd2, OP_PINS, 4'd0, 32'h0, 32'h01A5_59AE, 1'b0},
  '{3'd2, OP_READ, board_map_pkg::ADDR_CHAN0_CTRL, 32'h0, 32'h0000_015E, 1'b0},
  '{3'd2, OP_READ, board_map_pkg::ADDR_CHAN1_CTRL, 32'h0, 32'h0000_00B5, 1'b0},
  '{3'd2, OP_READ, board_map_pkg::ADDR_MISC, 32'h0, 32'h0000_0002, 1'b0},
  '{3'd2, OP_READ, 4'd6, 32'h0, 32'h0, 1'b0},
  '{3'd2, OP_READ, 4'd15, 32'h0, 32'h0, 1'b0},
  '{3'd2, OP_WRITE, 4'd7, 32'hFFFF_FFFF, 32'h0, 1'b0},
  '{3'd2, OP_READ, board_map_pkg::ADDR_BD_OUT, 32'h0, 32'h0000_00A5, 1'b0},
  // Core inputs are ignored while both channels are in pin mode
  '{3'd3, OP_CORE, 4'd0, 32'h0, 32'h0, 1'b1},
  '{3'd3, OP_PINS, 4'd0, 32'h0, 32'h01A5_59AE, 1'b0},
  '{3'd3, OP_WRITE, board_map_pkg::ADDR_CHAN0_CTRL, 32'h0000_015A, 32'h0, 1'b0},
  '{3'd3, OP_WRITE, board_map_pkg::ADDR_CHAN1_CTRL, 32'h0000_00B1, 32'h0, 1'b0},
  '{3'd3, OP_WAIT, 4'd0, 32'd2, 32'd0, 1'b0},
  '{3'd3, OP_PINS, 4'd0, 32'h0, 32'h01A5_58AC, 1'b1},
  '{3'd3, OP_CORE, 4'd0, 32'h0, 32'h0, 1'b1},
  '{3'd3, OP_PINS, 4'd0, 32'h0, 32'h01A5_58AC, 1'b1},
  '{3'd4, OP_STATUS, 4'd0, 32'h0, 32'h0, 1'b1},
  '{3'd4, OP_WAIT, 4'd0, 32'(SYNC_STAGES + 1), 32'd0, 1'b0},
  '{3'd4, OP_READ, board_map_pkg::ADDR_BD_IN, 32'h0, 32'h0, 1'b1},
  '{3'd4, OP_READ, board_map_pkg::ADDR_MISC, 32'h0, 32'h0000_0002, 1'b1},
  '{3'd4, OP_READ, board_map_pkg::ADDR_CHAN_STATUS, 32'h0, 32'h0, 1'b1},
  '{3'd4, OP_WAIT, 4'd0, 32'd1, 32'd0, 1'b0},
  '{3'd4, OP_READ, board_map_pkg::ADDR_CHAN_STATUS, 32'h0, 32'h0, 1'b1},
  // The request rises first and only its falling edge may pulse
  '{3'd5, OP_WRITE, board_map_pkg::ADDR_MISC, 32'h0000_0003, 32'h0, 1'b0},
  '{3'd5, OP_WAIT, 4'd0, 32'(SYNC_STAGES + 3), 32'd0, 1'b0},
  '{3'd5, OP_READ, board_map_pkg::ADDR_MISC, 32'h0, 32'h0000_0003, 1'b1},
  '{3'd5, OP_WRITE, board_map_pkg::ADDR_MISC, 32'h0000_0002, 32'h0, 1'b0},
  '{3'd5, OP_WAIT, 4'd0, 32'(SYNC_STAGES + 3), 32'd1, 1'b0},
  '{3'd5, OP_WRITE, board_map_pkg::ADDR_MISC, 32'h0000_0002, 32'h0, 1'b0},
  '{3'd5, OP_WAIT, 4'd0, 32'(SYNC_STAGES + 3), 32'd0, 1'b0}
};

`endif

// File: dv/xcvr_board_tb.sv
`timescale 1ns/1ns
`default_nettype none

module xcvr_board_tb;

  // Depth of the DUT synchronizers at their default value
  localparam int SYNC_STAGES  = 3;
  localparam int RESET_CYCLES = 8;
  localparam int DRIVE_DLY    = 2;

  `include "xcvr_board_tb_table.svh"

  localparam int MAX_CYCLES = NUM_ENTRIES * (SYNC_STAGES + 4) + RESET_CYCLES;

  logic                                ref_clk;
  logic                                sys_100m_resetn;
  logic                                up_wr_i;
  logic                                up_rd_i;
  logic [board_map_pkg::UP_ADDR_W-1:0] up_addr_i;
  logic [board_map_pkg::UP_DATA_W-1:0] up_wdata_i;
  logic [board_map_pkg::UP_DATA_W-1:0] up_rdata_o;
  logic                                up_rack_o;
  logic [12:0]                         gpio_bd_i;
  logic [7:0]                          gpio_bd_o;
  logic                                pll_lock_i;
  logic                                rf_en_o;
  logic                                mcs_sync_o;
  logic [7:0]                          status_0_i;
  logic [7:0]                          status_1_i;
  logic                                core_enable_0_i;
  logic                                core_txnrx_0_i;
  logic                                core_enable_1_i;
  logic                                core_txnrx_1_i;
  logic                                resetb_0_o;
  logic                                en_agc_0_o;
  logic [3:0]                          ctl_0_o;
  logic                                enable_0_o;
  logic                                txnrx_0_o;
  logic                                resetb_1_o;
  logic                                en_agc_1_o;
  logic [3:0]                          ctl_1_o;
  logic                                enable_1_o;
  logic                                txnrx_1_o;

  // Last values driven on the inputs, {lock, gpio_bd, status 1, status 0}
  logic [29:0] in_drv;
  // Flags that the status register should show, {chan1, chan0}
  logic [1:0]  chg_model;
  // Last core drive, {enable 1, txnrx 1, enable 0, txnrx 0}
  logic [3:0]  core_drv;
  int          seed = 3916;
  int          checks;
  int          fails;
  int          test_checks;
  int          test_fails;

  xcvr_board_top dut_i (
    .ref_clk         (ref_clk),
    .sys_100m_resetn (sys_100m_resetn),
    .up_wr_i         (up_wr_i),
    .up_rd_i         (up_rd_i),
    .up_addr_i       (up_addr_i),
    .up_wdata_i      (up_wdata_i),
    .up_rdata_o      (up_rdata_o),
    .up_rack_o       (up_rack_o),
    .gpio_bd_i       (gpio_bd_i),
    .gpio_bd_o       (gpio_bd_o),
    .pll_lock_i      (pll_lock_i),
    .rf_en_o         (rf_en_o),
    .mcs_sync_o      (mcs_sync_o),
    .status_0_i      (status_0_i),
    .core_enable_0_i (core_enable_0_i),
    .core_txnrx_0_i  (core_txnrx_0_i),
    .resetb_0_o      (resetb_0_o),
    .en_agc_0_o      (en_agc_0_o),
    .ctl_0_o         (ctl_0_o),
    .enable_0_o      (enable_0_o),
    .txnrx_0_o       (txnrx_0_o),
    .status_1_i      (status_1_i),
    .core_enable_1_i (core_enable_1_i),
    .core_txnrx_1_i  (core_txnrx_1_i),
    .resetb_1_o      (resetb_1_o),
    .en_agc_1_o      (en_agc_1_o),
    .ctl_1_o         (ctl_1_o),
    .enable_1_o      (enable_1_o),
    .txnrx_1_o       (txnrx_1_o)
  );

  initial begin
    ref_clk = 1'b0;
    forever #20 ref_clk = ~ref_clk;
  end

  // **************************************************
  // Helpers
  // **************************************************

  task automatic step();
    @(posedge ref_clk);
    #DRIVE_DLY;
  endtask

  function automatic logic [25:0] pins_now();
    return {mcs_sync_o, rf_en_o, gpio_bd_o,
            ctl_1_o, resetb_1_o, en_agc_1_o, enable_1_o, txnrx_1_o,
            ctl_0_o, resetb_0_o, en_agc_0_o, enable_0_o, txnrx_0_o};
  endfunction

  // Read-back bits that come from the driven board and status inputs
  function automatic logic [31:0] model_bits(input logic [3:0] addr);
    logic [31:0] v;
    v = '0;
    case (addr)
      board_map_pkg::ADDR_BD_IN: v[12:0] = in_drv[28:16];
      board_map_pkg::ADDR_CHAN_STATUS: v = {14'b0, chg_model, in_drv[15:0]};
      board_map_pkg::ADDR_MISC: v[2] = in_drv[29];
      default: v = '0;
    endcase
    return v;
  endfunction

  function automatic string test_name(input logic [2:0] tst);
    case (tst)
      3'd1: return "reset values";
      3'd2: return "register write and read-back";
      3'd3: return "enable and txnrx source";
      3'd4: return "input read-back";
      default: return "multi-chip sync";
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] got);
    checks++;
    test_checks++;
    assert (got === expv) else begin
      $display("Error at %0t ns: %s expected 0x%h, got 0x%h", $time, name, expv, got);
      fails++;
      test_fails++;
    end
  endtask

  // **************************************************
  // Table entry execution
  // **************************************************

  task automatic run_entry(input entry_t e);
    logic [31:0] expv;
    logic [31:0] rnd_word;
    logic [29:0] nv;
    int          pulses;
    case (e.op)
      OP_WRITE: begin
        up_addr_i  = e.addr;
        up_wdata_i = e.data;
        up_wr_i    = 1'b1;
        step();
        up_wr_i    = 1'b0;
      end
      OP_READ: begin
        up_addr_i = e.addr;
        up_rd_i   = 1'b1;
        step();
        up_rd_i   = 1'b0;
        while (up_rack_o !== 1'b1) step();
        expv = e.rnd ? (e.exp | model_bits(e.addr)) : e.exp;
        compare($sformatf("up_rdata_o at address %0d", e.addr), expv, up_rdata_o);
        // The acknowledged status read clears both flags
        if (e.addr == board_map_pkg::ADDR_CHAN_STATUS) chg_model = 2'b00;
      end
      OP_WAIT: begin
        pulses = 0;
        repeat (e.data) begin
          step();
          if (mcs_sync_o === 1'b1) pulses++;
        end
        compare("mcs_sync_o pulse count", e.exp, 32'(pulses));
      end
      OP_PINS: begin
        step();
        expv = e.exp;
        if (e.rnd) begin
          expv[9:8] = core_drv[3:2];
          expv[1:0] = core_drv[1:0];
        end
        compare("channel and board pins", expv, {6'b0, pins_now()});
      end
      OP_STATUS: begin
        rnd_word = $random(seed);
        nv = e.rnd ? rnd_word[29:0] : e.data[29:0];
        chg_model[0] = chg_model[0] | (nv[7:0] != in_drv[7:0]);
        chg_model[1] = chg_model[1] | (nv[15:8] != in_drv[15:8]);
        in_drv     = nv;
        status_0_i = nv[7:0];
        status_1_i = nv[15:8];
        gpio_bd_i  = nv[28:16];
        pll_lock_i = nv[29];
        step();
      end
      default: begin
        rnd_word = $random(seed);
        core_drv = e.rnd ? rnd_word[3:0] : e.data[3:0];
        core_enable_1_i = core_drv[3];
        core_txnrx_1_i  = core_drv[2];
        core_enable_0_i = core_drv[1];
        core_txnrx_0_i  = core_drv[0];
        step();
      end
    endcase
  endtask

  task automatic report_test(input logic [2:0] tst);
    $display("Test %0d, %s: %0d checks, %0d failed", tst, test_name(tst),
             test_checks, test_fails);
    test_checks = 0;
    test_fails  = 0;
  endtask

  // **************************************************
  // Main sequence and watchdog
  // **************************************************

  initial begin
    logic [2:0] cur_tst;
    sys_100m_resetn = 1'b0;
    up_wr_i    = 1'b0;
    up_rd_i    = 1'b0;
    up_addr_i  = '0;
    up_wdata_i = '0;
    gpio_bd_i  = '0;
    pll_lock_i = 1'b0;
    status_0_i = '0;
    status_1_i = '0;
    core_enable_0_i = 1'b0;
    core_txnrx_0_i  = 1'b0;
    core_enable_1_i = 1'b0;
    core_txnrx_1_i  = 1'b0;
    in_drv    = '0;
    chg_model = 2'b00;
    core_drv  = 4'h0;
    repeat (RESET_CYCLES) @(posedge ref_clk);
    #DRIVE_DLY;
    sys_100m_resetn = 1'b1;
    cur_tst = STIM_TABLE[0].tst;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (STIM_TABLE[i].tst != cur_tst) begin
        report_test(cur_tst);
        cur_tst = STIM_TABLE[i].tst;
      end
      run_entry(STIM_TABLE[i]);
    end
    report_test(cur_tst);
    $display("Checks passed: %0d, failed: %0d", checks - fails, fails);
    if (fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge ref_clk);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+dv
rtl/board_map_pkg.sv
rtl/xcvr_ctrl_pkg.sv
rtl/xcvr_chan_ctrl.sv
rtl/gpio_regs.sv
rtl/xcvr_board_top.sv
dv/xcvr_board_tb.sv

// File: Makefile
# Verilator build and run of the transceiver board control testbench

TOP := xcvr_board_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f filelist.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "Test failures found" sim.log; then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
